// ==== dcache_top.f ====
dcache_pkg.sv
dcache_array_if.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache_top.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_array_if.sv
  - dcache_array.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_asserts.sv
      - tb_dcache_top.sv

// ==== tb_dcache_top.sv ====
//######################################################################
// directed testbench for the data cache, with bus memory model
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;
    import dcache_pkg::*;

    // five short tests of well under 400 cycles each at max bus latency
    localparam int TIMEOUT_CYCLES = 4000;

    logic  CLK, nRST;
    logic  dmemREN, dmemWEN, datomic, halt;
    word_t dmemaddr, dmemstore, dmemload;
    logic  dhit, flushed, dREN, dWEN, dwait, ccwait, ccinv, ccwrite, cctrans;
    word_t daddr, dstore, dload, ccsnoopaddr;

    word_t       mem [word_t];  // sparse bus memory
    word_t       wb_addrs [$];  // addresses of all bus writes in order
    int          rd_count;
    int          wait_left;
    logic [15:0] lfsr = 16'd63026;
    int          cycles;
    int          errors;
    int          tests_failed;

    dcache_top u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic word_t model_word(input word_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'hA5A5_0000);
    endfunction

    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int bus_delay();
        logic [1:0] d;
        d[0] = lfsr_step();
        d[1] = lfsr_step();
        return int'(d);
    endfunction

    // memory side of the bus drops dwait after a random delay
    always @(posedge CLK) begin
        if (!dwait) begin
            if (dWEN) begin
                mem[daddr] = dstore;
                wb_addrs.push_back(daddr);
            end
            if (dREN)
                rd_count++;
            dwait     <= 1'b1;
            wait_left = bus_delay();
        end else if (dREN || dWEN) begin
            if (wait_left == 0) begin
                dwait <= 1'b0;
                dload <= model_word(daddr);
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic value_mismatch(input string name, input word_t got, input word_t exp);
        $display("error %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic test_done(input string name, input int start);
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed, %0d bad checks", name, errors - start);
            tests_failed++;
        end
    endtask

    // one datapath request held until dhit
    task automatic access(input logic wr, input logic atomic, input word_t addr,
                          input word_t data, output word_t load, output int reads,
                          output logic trans);
        int reads0;
        reads0 = rd_count;
        @(posedge CLK);
        dmemREN   <= !wr;
        dmemWEN   <= wr;
        datomic   <= atomic;
        dmemaddr  <= addr;
        dmemstore <= data;
        @(negedge CLK);
        while (!dhit)
            @(negedge CLK);
        load  = dmemload;
        trans = cctrans;
        reads = rd_count - reads0;
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        datomic <= 1'b0;
    endtask

    task automatic snoop(input word_t addr, input logic inv, output logic hit,
                         output word_t data, output word_t addr_seen);
        @(posedge CLK);
        ccwait      <= 1'b1;
        ccinv       <= inv;
        ccsnoopaddr <= addr;
        @(negedge CLK);
        hit       = ccwrite;
        data      = dstore;
        addr_seen = daddr;
        if (ccwrite)
            mem[addr] = dstore;  // supplied word lands in memory
        @(posedge CLK);
        ccwait <= 1'b0;
        ccinv  <= 1'b0;
    endtask

    task automatic read_miss_then_hit();
        word_t a, load;
        int    reads, start;
        logic  trans;
        start = errors;
        a     = 32'h0000_1040;
        if (dREN || dWEN || dhit || flushed || ccwrite || cctrans)
            report_failure("an output was high right after reset");
        access(1'b0, 1'b0, a, '0, load, reads, trans);
        if (reads != 2)
            report_failure($sformatf("read miss made %0d bus reads instead of 2", reads));
        if (load !== model_word(a))
            value_mismatch("dmemload", load, model_word(a));
        access(1'b0, 1'b0, a ^ 32'h4, '0, load, reads, trans);
        if (reads != 0)
            report_failure("read of the other block word went to the bus");
        if (load !== model_word(a ^ 32'h4))
            value_mismatch("dmemload", load, model_word(a ^ 32'h4));
        test_done("read_miss_then_hit", start);
    endtask

    task automatic write_hit_and_evict();
        word_t b, load;
        word_t others [3];
        int    reads, start, wb0;
        logic  trans;
        start  = errors;
        b      = 32'h0000_2008;
        others = '{32'h0000_3008, 32'h0000_4008, 32'h0000_5008};  // same set
        access(1'b1, 1'b0, b, 32'hDEAD_0001, load, reads, trans);
        if (trans !== 1'b1)
            value_mismatch("cctrans", word_t'(trans), 32'h1);
        wb0 = wb_addrs.size();
        foreach (others[i]) begin
            access(1'b0, 1'b0, others[i], '0, load, reads, trans);
            if (load !== model_word(others[i]))
                value_mismatch("dmemload", load, model_word(others[i]));
        end
        if (wb_addrs.size() - wb0 != 2)
            report_failure($sformatf("saw %0d bus writes, one block write-back expected",
                                     wb_addrs.size() - wb0));
        if (model_word(b) !== 32'hDEAD_0001)
            value_mismatch("memory word", model_word(b), 32'hDEAD_0001);
        test_done("write_hit_and_evict", start);
    endtask

    task automatic link_register();
        word_t l, load, sdata, saddr;
        int    reads, start;
        logic  trans, shit;
        start = errors;
        l     = 32'h0000_6010;
        access(1'b0, 1'b1, l, '0, load, reads, trans);  // LL
        access(1'b1, 1'b1, l, 32'h5C5C_0001, load, reads, trans);
        if (load !== 32'h1)
            value_mismatch("dmemload", load, 32'h1);
        if (trans !== 1'b1)
            value_mismatch("cctrans", word_t'(trans), 32'h1);
        access(1'b1, 1'b1, l, 32'h5C5C_0002, load, reads, trans);  // link gone
        if (load !== 32'h0)
            value_mismatch("dmemload", load, 32'h0);
        access(1'b0, 1'b0, l, '0, load, reads, trans);
        if (load !== 32'h5C5C_0001)
            value_mismatch("dmemload", load, 32'h5C5C_0001);
        access(1'b0, 1'b1, l, '0, load, reads, trans);
        snoop(l, 1'b0, shit, sdata, saddr);
        access(1'b1, 1'b1, l, 32'h5C5C_0003, load, reads, trans);
        if (load !== 32'h0)
            value_mismatch("dmemload", load, 32'h0);
        access(1'b0, 1'b0, l, '0, load, reads, trans);
        if (load !== 32'h5C5C_0001)
            value_mismatch("dmemload", load, 32'h5C5C_0001);
        test_done("link_register", start);
    endtask

    task automatic snoop_invalidate();
        word_t s, load, sdata, saddr;
        int    reads, start;
        logic  trans, shit;
        start = errors;
        s     = 32'h0000_7018;
        access(1'b1, 1'b0, s, 32'h5000_0001, load, reads, trans);
        snoop(32'h0000_7318, 1'b1, shit, sdata, saddr);
        if (shit !== 1'b0)
            report_failure("snoop to an uncached word raised ccwrite");
        snoop(s, 1'b1, shit, sdata, saddr);
        if (shit !== 1'b1)
            report_failure("snoop to a cached word left ccwrite low");
        if (sdata !== 32'h5000_0001)
            value_mismatch("dstore", sdata, 32'h5000_0001);
        if (saddr !== s)
            value_mismatch("daddr", saddr, s);
        access(1'b0, 1'b0, s, '0, load, reads, trans);
        if (reads != 2)
            report_failure("read after an invalidating snoop did not miss");
        if (load !== 32'h5000_0001)
            value_mismatch("dmemload", load, 32'h5000_0001);
        test_done("snoop_invalidate", start);
    endtask

    task automatic halt_flush();
        word_t addrs [4];
        word_t vals [4];
        word_t blocks [3];
        word_t load;
        int    reads, start, wb0;
        logic  trans, known;
        start  = errors;
        addrs  = '{32'h0000_8020, 32'h0000_9028, 32'h0000_902C, 32'h0000_B030};
        vals   = '{32'hF1F1_0001, 32'hF2F2_0002, 32'hF3F3_0003, 32'hF4F4_0004};
        blocks = '{32'h0000_8020, 32'h0000_9028, 32'h0000_B030};
        foreach (addrs[i])
            access(1'b1, 1'b0, addrs[i], vals[i], load, reads, trans);
        access(1'b0, 1'b0, 32'h0000_C038, '0, load, reads, trans);  // clean frame
        wb0 = wb_addrs.size();
        @(posedge CLK);
        halt <= 1'b1;
        @(negedge CLK);
        while (!flushed)
            @(negedge CLK);
        if (wb_addrs.size() - wb0 != 6)
            report_failure($sformatf("flush wrote %0d words, 6 expected",
                                     wb_addrs.size() - wb0));
        for (int i = wb0; i < wb_addrs.size(); i++) begin
            known = 1'b0;
            foreach (blocks[j])
                if ((wb_addrs[i] & ~32'h7) == blocks[j])
                    known = 1'b1;
            if (!known)
                report_failure($sformatf("clean word %h written back by flush", wb_addrs[i]));
        end
        foreach (addrs[i])
            if (model_word(addrs[i]) !== vals[i])
                value_mismatch("memory word", model_word(addrs[i]), vals[i]);
        test_done("halt_flush", start);
    endtask

    initial begin
        nRST        = 1'b0;
        dmemREN     = 1'b0;
        dmemWEN     = 1'b0;
        datomic     = 1'b0;
        halt        = 1'b0;
        dmemaddr    = '0;
        dmemstore   = '0;
        dload       = '0;
        dwait       = 1'b1;
        ccwait      = 1'b0;
        ccinv       = 1'b0;
        ccsnoopaddr = '0;
        wait_left   = 0;
        rd_count    = 0;
        cycles      = 0;
        errors      = 0;
        tests_failed = 0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        read_miss_then_hit();
        write_hit_and_evict();
        link_register();
        snoop_invalidate();
        halt_flush();
        errors += u_dut.u_ctrl.u_asserts.fail_count;  // bound assertion failures
        $display("tests run 5, tests failed %0d, bad checks %0d", tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_asserts.sv ====
//######################################################################
// bus handshake and flushed assertions, bound to the cache controller
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       dREN,
    input  logic                       dWEN,
    input  logic                       dwait,
    input  logic                       ccwait,
    input  logic                       flushed,
    input  dcache_pkg::word_t          daddr,
    input  dcache_pkg::dcache_state_t  state
);
    import dcache_pkg::*;

    int fail_count = 0;  // failed assertion count

    a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
        !(dREN && dWEN))
        else begin
            $error("dREN and dWEN high together");
            fail_count++;
        end

    // address held while the bus stalls
    a_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (dREN || dWEN) && dwait |=> ccwait || $stable(daddr))
        else begin
            $error("daddr changed during a stalled transfer");
            fail_count++;
        end

    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else begin
            $error("flushed fell after rising");
            fail_count++;
        end

    a_halted_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        state == HALTED |-> !dREN && !dWEN)
        else begin
            $error("bus request after the flush finished");
            fail_count++;
        end

endmodule

bind dcache_ctrl dcache_asserts u_asserts (
    .CLK     (CLK),
    .nRST    (nRST),
    .dREN    (dREN),
    .dWEN    (dWEN),
    .dwait   (dwait),
    .ccwait  (ccwait),
    .flushed (flushed),
    .daddr   (daddr),
    .state   (state)
);

`default_nettype wire

// ==== dcache_top.sv ====
//######################################################################
// data cache top level, array and controller joined by the array interface
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic               CLK,
    input  logic               nRST,
    // datapath side
    input  logic               dmemREN,
    input  logic               dmemWEN,
    input  logic               datomic,
    input  logic               halt,
    input  dcache_pkg::word_t  dmemaddr,
    input  dcache_pkg::word_t  dmemstore,
    output logic               dhit,
    output dcache_pkg::word_t  dmemload,
    output logic               flushed,
    // memory bus
    output logic               dREN,
    output logic               dWEN,
    output dcache_pkg::word_t  daddr,
    output dcache_pkg::word_t  dstore,
    input  dcache_pkg::word_t  dload,
    input  logic               dwait,
    // snoop
    input  logic               ccwait,
    input  logic               ccinv,
    input  dcache_pkg::word_t  ccsnoopaddr,
    output logic               ccwrite,
    output logic               cctrans
);

    dcache_array_if arr_if ();

    dcache_array u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr_if.array)
    );

    dcache_ctrl u_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmemREN     (dmemREN),
        .dmemWEN     (dmemWEN),
        .datomic     (datomic),
        .halt        (halt),
        .dmemaddr    (dmemaddr),
        .dmemstore   (dmemstore),
        .dhit        (dhit),
        .dmemload    (dmemload),
        .flushed     (flushed),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .daddr       (daddr),
        .dstore      (dstore),
        .dload       (dload),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .ccwrite     (ccwrite),
        .cctrans     (cctrans),
        .arr         (arr_if.ctrl)
    );

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
//######################################################################
// miss, write-back, flush and snoop FSM with the link register
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               dmemREN,
    input  logic               dmemWEN,
    input  logic               datomic,
    input  logic               halt,
    input  dcache_pkg::word_t  dmemaddr,
    input  dcache_pkg::word_t  dmemstore,
    output logic               dhit,
    output dcache_pkg::word_t  dmemload,
    output logic               flushed,
    output logic               dREN,
    output logic               dWEN,
    output dcache_pkg::word_t  daddr,
    output dcache_pkg::word_t  dstore,
    input  dcache_pkg::word_t  dload,
    input  logic               dwait,
    input  logic               ccwait,
    input  logic               ccinv,
    input  dcache_pkg::word_t  ccsnoopaddr,
    output logic               ccwrite,
    output logic               cctrans,
    dcache_array_if.ctrl       arr
);
    import dcache_pkg::*;

    dcache_state_t              state, next_state;
    logic [$clog2(FRAMES)-1:0]  row, next_row;        // flush frame
    logic                       link_valid, next_link_valid;
    word_t                      link_addr, next_link_addr;
    dcache_addr_t               req;
    logic                       sc_ok;

    // block word address from tag, set and word
    function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                       input logic [IDX_W-1:0] idx,
                                       input logic             blk);
        return {tag, idx, blk, 2'b00};
    endfunction

    assign req             = dcache_addr_t'(dmemaddr);
    assign arr.addr        = req;
    assign arr.snoop_addr  = dcache_addr_t'(ccsnoopaddr);
    assign arr.write_data  = dmemstore;
    assign arr.fill_data   = dload;
    assign arr.flush_frame = row;
    assign sc_ok           = link_valid && (link_addr == dmemaddr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            row        <= '0;
            link_valid <= 1'b0;
        end else begin
            state      <= next_state;
            row        <= next_row;
            link_valid <= next_link_valid;
        end
    end

    always_ff @(posedge CLK) begin
        link_addr <= next_link_addr;
    end

    always_comb begin
        next_state      = state;
        next_row        = row;
        next_link_valid = link_valid;
        next_link_addr  = link_addr;
        dhit = 1'b0;
        dmemload = '0;
        flushed = (state == HALTED);  // stays until reset
        dREN = 1'b0;
        dWEN = 1'b0;
        daddr = '0;
        dstore = '0;
        ccwrite = 1'b0;
        cctrans = 1'b0;
        arr.write_en    = 1'b0;
        arr.fill_en     = 1'b0;
        arr.fill_word   = 1'b0;
        arr.fill_done   = 1'b0;
        arr.touch       = 1'b0;
        arr.snoop_clean = 1'b0;
        arr.snoop_inval = 1'b0;
        arr.flush_clean = 1'b0;

        if (ccwait) begin
            // serve the snoop while the FSM holds
            if (arr.snoop_hit) begin
                ccwrite = 1'b1;
                daddr   = ccsnoopaddr;
                dstore  = arr.snoop_data;
                arr.snoop_inval = ccinv;
                arr.snoop_clean = !ccinv;
            end
            if (link_valid && ccsnoopaddr == link_addr)
                next_link_valid = 1'b0;  // another core touched the linked word
        end else begin
            case (state)
                IDLE: begin
                    if (halt) begin
                        next_state = FL_SCAN;
                    end else if ((dmemREN || dmemWEN) && arr.hit) begin
                        dhit      = 1'b1;
                        arr.touch = 1'b1;
                        if (dmemREN) begin
                            dmemload = arr.hit_data;
                            if (datomic) begin  // LL
                                next_link_valid = 1'b1;
                                next_link_addr  = dmemaddr;
                            end
                        end else if (datomic) begin  // SC
                            dmemload        = word_t'(sc_ok);
                            arr.write_en    = sc_ok;
                            next_link_valid = 1'b0;
                        end else begin
                            arr.write_en = 1'b1;
                        end
                        cctrans = arr.write_en;
                        if (arr.write_en)
                            daddr = dmemaddr;
                    end else if (dmemREN || dmemWEN) begin
                        next_state = (arr.victim_valid && arr.victim_dirty) ? WB1 : RD1;
                    end
                end
                WB1, WB2: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(arr.victim_tag, req.idx, state == WB2);
                    dstore = arr.victim_data[state == WB2];
                    if (!dwait)
                        next_state = (state == WB1) ? WB2 : RD1;
                end
                RD1, RD2: begin
                    dREN  = 1'b1;
                    daddr = blk_addr(req.tag, req.idx, state == RD2);
                    if (!dwait) begin
                        arr.fill_en   = 1'b1;
                        arr.fill_word = (state == RD2);
                        arr.fill_done = (state == RD2);
                        next_state    = (state == RD1) ? RD2 : IDLE;
                    end
                end
                FL_SCAN: begin
                    if (arr.frame_dirty)
                        next_state = FL1;
                    else if (row == FRAMES - 1)
                        next_state = HALTED;
                    else
                        next_row = row + 1'b1;
                end
                FL1, FL2: begin
                    dWEN   = 1'b1;
                    daddr  = blk_addr(arr.frame_tag, row[IDX_W:1], state == FL2);
                    dstore = arr.frame_data[state == FL2];
                    if (!dwait) begin
                        arr.flush_clean = (state == FL2);
                        next_state      = (state == FL1) ? FL2 : FL_SCAN;
                    end
                end
                HALTED:  next_state = HALTED;
                default: next_state = IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dcache_array.sv ====
//######################################################################
// tag, data, valid, dirty and lru storage with lookup and snoop ports
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
    input  logic              CLK,
    input  logic              nRST,
    dcache_array_if.array     arr
);
    import dcache_pkg::*;

    // control state
    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;
    logic [SETS-1:0]           lru_q;      // way to evict next

    // payload
    logic [TAG_W-1:0]          tag_q  [SETS][WAYS];
    word_t                     data_q [SETS][WAYS][BLK_WORDS];

    logic [IDX_W-1:0]          idx;
    logic [IDX_W-1:0]          sidx;
    logic [IDX_W-1:0]          fset;
    logic                      vway;
    logic                      sway;
    logic                      fway;

    assign idx  = arr.addr.idx;
    assign sidx = arr.snoop_addr.idx;
    assign vway = lru_q[idx];
    assign fset = arr.flush_frame[IDX_W:1];
    assign fway = arr.flush_frame[0];

    // datapath and snoop tag compare
    always_comb begin
        arr.hit     = 1'b0;
        arr.hit_way = 1'b0;
        arr.snoop_hit = 1'b0;
        sway = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[idx][w] && tag_q[idx][w] == arr.addr.tag) begin
                arr.hit     = 1'b1;
                arr.hit_way = 1'(w);
            end
            if (valid_q[sidx][w] && tag_q[sidx][w] == arr.snoop_addr.tag) begin
                arr.snoop_hit = 1'b1;
                sway = 1'(w);
            end
        end
    end

    assign arr.hit_data   = data_q[idx][arr.hit_way][arr.addr.blkoff];
    assign arr.snoop_data = data_q[sidx][sway][arr.snoop_addr.blkoff];

    assign arr.victim_valid = valid_q[idx][vway];
    assign arr.victim_dirty = dirty_q[idx][vway];
    assign arr.victim_tag   = tag_q[idx][vway];
    assign arr.frame_dirty  = dirty_q[fset][fway];  // dirty implies valid
    assign arr.frame_tag    = tag_q[fset][fway];

    always_comb begin
        for (int b = 0; b < BLK_WORDS; b++) begin
            arr.victim_data[b] = data_q[idx][vway][b];
            arr.frame_data[b]  = data_q[fset][fway][b];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (arr.write_en)
                dirty_q[idx][arr.hit_way] <= 1'b1;
            if (arr.touch)
                lru_q[idx] <= ~arr.hit_way;
            if (arr.fill_done) begin
                valid_q[idx][vway] <= 1'b1;
                dirty_q[idx][vway] <= 1'b0;
                lru_q[idx]         <= ~vway;
            end
            if (arr.snoop_clean)
                dirty_q[sidx][sway] <= 1'b0;
            if (arr.snoop_inval) begin
                valid_q[sidx][sway] <= 1'b0;
                dirty_q[sidx][sway] <= 1'b0;  // nothing left to flush
            end
            if (arr.flush_clean)
                dirty_q[fset][fway] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (arr.write_en)
            data_q[idx][arr.hit_way][arr.addr.blkoff] <= arr.write_data;
        if (arr.fill_en)
            data_q[idx][vway][arr.fill_word] <= arr.fill_data;
        if (arr.fill_done)
            tag_q[idx][vway] <= arr.addr.tag;
    end

endmodule

`default_nettype wire

// ==== dcache_array_if.sv ====
//######################################################################
// controller to storage array interface, ctrl and array modports
//######################################################################
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;
    import dcache_pkg::*;

    // driven by the controller
    dcache_addr_t                addr;         // datapath lookup
    logic                        write_en;
    word_t                       write_data;
    logic                        fill_en;      // refill one word of the lru way
    logic                        fill_word;
    word_t                       fill_data;
    logic                        fill_done;    // tag, valid, clean
    logic                        touch;
    dcache_addr_t                snoop_addr;
    logic                        snoop_clean;
    logic                        snoop_inval;
    logic [$clog2(FRAMES)-1:0]   flush_frame;  // {set, way}
    logic                        flush_clean;

    // driven by the array
    logic                        hit;
    logic                        hit_way;
    word_t                       hit_data;
    logic                        victim_valid;
    logic                        victim_dirty;
    logic [TAG_W-1:0]            victim_tag;
    word_t [BLK_WORDS-1:0]       victim_data;
    logic                        snoop_hit;
    word_t                       snoop_data;
    logic                        frame_dirty;
    logic [TAG_W-1:0]            frame_tag;
    word_t [BLK_WORDS-1:0]       frame_data;

    modport ctrl (
        output addr, write_en, write_data, fill_en, fill_word, fill_data, fill_done,
               touch, snoop_addr, snoop_clean, snoop_inval, flush_frame, flush_clean,
        input  hit, hit_way, hit_data, victim_valid, victim_dirty, victim_tag,
               victim_data, snoop_hit, snoop_data, frame_dirty, frame_tag, frame_data
    );

    modport array (
        input  addr, write_en, write_data, fill_en, fill_word, fill_data, fill_done,
               touch, snoop_addr, snoop_clean, snoop_inval, flush_frame, flush_clean,
        output hit, hit_way, hit_data, victim_valid, victim_dirty, victim_tag,
               victim_data, snoop_hit, snoop_data, frame_dirty, frame_tag, frame_data
    );

endinterface

`default_nettype wire

// ==== dcache_pkg.sv ====
//######################################################################
// data cache geometry, word and address types, controller state enum
//######################################################################
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int WAYS      = 2;
    localparam int SETS      = 8;
    localparam int BLK_WORDS = 2;
    localparam int TAG_W     = 26;
    localparam int IDX_W     = 3;
    localparam int FRAMES    = WAYS * SETS;  // flush scan range

    typedef logic [31:0] word_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;  // word within block
        logic [1:0]       bytoff;
    } dcache_addr_t;

    // controller states
    typedef enum logic [3:0] {
        IDLE,      // serve hits, detect misses
        WB1,       // write back victim word 0
        WB2,       // write back victim word 1
        RD1,       // refill word 0
        RD2,       // refill word 1
        FL_SCAN,   // walk frames looking for dirty ones
        FL1,
        FL2,
        HALTED     // flush complete
    } dcache_state_t;

endpackage

`default_nettype wire
